//--- hw/corePkg.sv
package corePkg;

   // register file geometry.
   localparam int regIdxWidth = 4;
   localparam int numRegs = 16;

   // instruction field widths.
   localparam int opcodeWidth = 8;
   localparam int immWidth = 16;
   localparam int unusedWidth = 12;

   // widest data path, the decoded immediate is extended to this.
   localparam int extImmWidth = 64;

   // opcode bit that selects the immediate form.
   localparam int opImmBit = 7;

   // register form opcodes.
   localparam logic [opcodeWidth-1:0] opAdd = 8'h01;
   localparam logic [opcodeWidth-1:0] opSub = 8'h02;
   localparam logic [opcodeWidth-1:0] opAnd = 8'h03;
   localparam logic [opcodeWidth-1:0] opOr = 8'h04;
   localparam logic [opcodeWidth-1:0] opXor = 8'h05;
   localparam logic [opcodeWidth-1:0] opMov = 8'h06;
   localparam logic [opcodeWidth-1:0] opShl = 8'h07;

   // immediate form opcodes, the base op with opImmBit set.
   localparam logic [opcodeWidth-1:0] opAddI = 8'h81;
   localparam logic [opcodeWidth-1:0] opMovI = 8'h86;

   typedef struct packed {
      logic [opcodeWidth-1:0] opcode;
      logic [regIdxWidth-1:0] dest;
      logic [regIdxWidth-1:0] src1;
      logic [regIdxWidth-1:0] src2;
      logic [unusedWidth-1:0] unused;
   } regFormFields;

   typedef struct packed {
      logic [opcodeWidth-1:0] opcode;
      logic [regIdxWidth-1:0] dest;
      logic [regIdxWidth-1:0] src1;
      logic signed [immWidth-1:0] imm;
   } immFormFields;

   // one 32-bit word, two views selected by opImmBit.
   typedef union packed {
      regFormFields regForm;
      immFormFields immForm;
   } instrWord;

endpackage

//--- hw/opcodeDecode.sv
module opcodeDecode (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                instrValid,
   input  logic                                stall,
   input  corePkg::instrWord                   instr,
   output logic                                decValid,
   output logic [corePkg::opcodeWidth-1:0]     decOpcode,
   output logic [corePkg::regIdxWidth-1:0]     decDest,
   output logic [corePkg::regIdxWidth-1:0]     decSrc1,
   output logic                                decSrc1Valid,
   output logic [corePkg::regIdxWidth-1:0]     decSrc2,
   output logic                                decSrc2Valid,
   output logic [corePkg::extImmWidth-1:0]     decImm,
   output logic                                decUseImm
);

   logic [corePkg::opcodeWidth-1:0] opcode;
   logic useImm;
   logic legal;
   logic accept;

   assign opcode = instr.regForm.opcode;
   assign useImm = opcode[corePkg::opImmBit];
   assign accept = instrValid && !stall;

   always_comb begin
      case (opcode)
         corePkg::opAdd, corePkg::opSub, corePkg::opAnd, corePkg::opOr,
         corePkg::opXor, corePkg::opMov, corePkg::opShl,
         corePkg::opAddI, corePkg::opMovI: legal = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   // the stage holds while stall is high; illegal words never become valid.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decValid <= 1'b0;
      end else if (!stall) begin
         decValid <= instrValid && legal;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         decOpcode <= opcode;
         decDest <= instr.regForm.dest;
         decSrc1 <= instr.regForm.src1;
         // movi reads no register at all.
         decSrc1Valid <= (opcode != corePkg::opMovI);
         decSrc2 <= useImm ? '0 : instr.regForm.src2;
         decSrc2Valid <= !useImm && (opcode != corePkg::opMov);
         decImm <= {{(corePkg::extImmWidth - corePkg::immWidth){instr.immForm.imm[corePkg::immWidth-1]}},
                    instr.immForm.imm};
         decUseImm <= useImm;
      end
   end

endmodule

//--- hw/operandRead.sv
module operandRead #(
   parameter int dataWidth = 64
) (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                decValid,
   input  logic [corePkg::opcodeWidth-1:0]     decOpcode,
   input  logic [corePkg::regIdxWidth-1:0]     decDest,
   input  logic [corePkg::regIdxWidth-1:0]     decSrc1,
   input  logic                                decSrc1Valid,
   input  logic [corePkg::regIdxWidth-1:0]     decSrc2,
   input  logic                                decSrc2Valid,
   input  logic [corePkg::extImmWidth-1:0]     decImm,
   input  logic                                decUseImm,
   input  logic                                exValid,
   input  logic [corePkg::regIdxWidth-1:0]     exDest,
   input  logic                                wbValid,
   input  logic [corePkg::regIdxWidth-1:0]     wbDest,
   input  logic [dataWidth-1:0]                registerFile [corePkg::numRegs],
   output logic                                stall,
   output logic                                rdValid,
   output logic [corePkg::opcodeWidth-1:0]     rdOpcode,
   output logic [corePkg::regIdxWidth-1:0]     rdDest,
   output logic [dataWidth-1:0]                rdOperand1,
   output logic [dataWidth-1:0]                rdOperand2,
   output logic [dataWidth-1:0]                rdImm,
   output logic                                rdUseImm
);

   logic src1Hazard;
   logic src2Hazard;
   logic issue;

   // true while some older instruction still has to write this register.
   // rd is in execute, ex waits for writeback, wb is the write just done.
   function automatic logic inFlight(input logic [corePkg::regIdxWidth-1:0] idx);
      inFlight = (rdValid && (rdDest == idx))
              || (exValid && (exDest == idx))
              || (wbValid && (wbDest == idx));
   endfunction

   always_comb begin
      src1Hazard = decSrc1Valid && inFlight(decSrc1);
      src2Hazard = decSrc2Valid && inFlight(decSrc2);
   end

   assign stall = decValid && (src1Hazard || src2Hazard);
   assign issue = decValid && !stall;

   // a stalled cycle sends a bubble into execute.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rdValid <= 1'b0;
      end else begin
         rdValid <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         rdOpcode <= decOpcode;
         rdDest <= decDest;
         rdOperand1 <= decSrc1Valid ? registerFile[decSrc1] : '0;
         rdOperand2 <= decSrc2Valid ? registerFile[decSrc2] : '0;
         rdImm <= decImm[dataWidth-1:0];
         rdUseImm <= decUseImm;
      end
   end

endmodule

//--- hw/aluExecute.sv
module aluExecute #(
   parameter int dataWidth = 64
) (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                rdValid,
   input  logic [corePkg::opcodeWidth-1:0]     rdOpcode,
   input  logic [corePkg::regIdxWidth-1:0]     rdDest,
   input  logic [dataWidth-1:0]                rdOperand1,
   input  logic [dataWidth-1:0]                rdOperand2,
   input  logic [dataWidth-1:0]                rdImm,
   input  logic                                rdUseImm,
   output logic                                exValid,
   output logic [corePkg::regIdxWidth-1:0]     exDest,
   output logic [dataWidth-1:0]                exValue
);

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluOut;

   assign opA = rdOperand1;
   // immediate forms take the extended immediate as the second input.
   assign opB = rdUseImm ? rdImm : rdOperand2;

   always_comb begin
      case (rdOpcode)
         corePkg::opAdd, corePkg::opAddI: aluOut = opA + opB;
         corePkg::opSub: aluOut = opA - opB;
         corePkg::opAnd: aluOut = opA & opB;
         corePkg::opOr: aluOut = opA | opB;
         corePkg::opXor: aluOut = opA ^ opB;
         corePkg::opMov: aluOut = opA;
         corePkg::opMovI: aluOut = opB;
         corePkg::opShl: aluOut = opA << opB[5:0];
         default: aluOut = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exValid <= 1'b0;
      end else begin
         exValid <= rdValid;
      end
   end

   always_ff @(posedge clk) begin
      if (rdValid) begin
         exDest <= rdDest;
         exValue <= aluOut;
      end
   end

endmodule

//--- hw/resultWriteback.sv
module resultWriteback #(
   parameter int dataWidth = 64
) (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                exValid,
   input  logic [corePkg::regIdxWidth-1:0]     exDest,
   input  logic [dataWidth-1:0]                exValue,
   output logic [dataWidth-1:0]                registerFile [corePkg::numRegs],
   output logic                                wbValid,
   output logic [corePkg::regIdxWidth-1:0]     wbDest,
   output logic                                resultValid,
   output logic [corePkg::regIdxWidth-1:0]     resultReg,
   output logic [dataWidth-1:0]                resultValue
);

   // the write and the result strobe land on the same edge.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < corePkg::numRegs; i++) begin
            registerFile[i] <= '0;
         end
         resultValid <= 1'b0;
         resultReg <= '0;
         resultValue <= '0;
      end else begin
         resultValid <= exValid;
         if (exValid) begin
            registerFile[exDest] <= exValue;
            resultReg <= exDest;
            resultValue <= exValue;
         end
      end
   end

   // the last write, fed back to the hazard check in the read stage.
   assign wbValid = resultValid;
   assign wbDest = resultReg;

endmodule

//--- hw/miniCore.sv
module miniCore #(
   parameter int dataWidth = 64
) (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                instrValid,
   input  corePkg::instrWord                   instr,
   output logic                                stall,
   output logic                                resultValid,
   output logic [corePkg::regIdxWidth-1:0]     resultReg,
   output logic [dataWidth-1:0]                resultValue
);

   // decode to read.
   logic decValid;
   logic [corePkg::opcodeWidth-1:0] decOpcode;
   logic [corePkg::regIdxWidth-1:0] decDest;
   logic [corePkg::regIdxWidth-1:0] decSrc1;
   logic decSrc1Valid;
   logic [corePkg::regIdxWidth-1:0] decSrc2;
   logic decSrc2Valid;
   logic [corePkg::extImmWidth-1:0] decImm;
   logic decUseImm;

   // read to execute.
   logic rdValid;
   logic [corePkg::opcodeWidth-1:0] rdOpcode;
   logic [corePkg::regIdxWidth-1:0] rdDest;
   logic [dataWidth-1:0] rdOperand1;
   logic [dataWidth-1:0] rdOperand2;
   logic [dataWidth-1:0] rdImm;
   logic rdUseImm;

   // execute to writeback, also seen by the hazard check.
   logic exValid;
   logic [corePkg::regIdxWidth-1:0] exDest;
   logic [dataWidth-1:0] exValue;

   logic wbValid;
   logic [corePkg::regIdxWidth-1:0] wbDest;
   logic [dataWidth-1:0] registerFile [corePkg::numRegs];

   opcodeDecode decode_i (
      .clk, .rstN, .instrValid, .stall, .instr,
      .decValid, .decOpcode, .decDest, .decSrc1, .decSrc1Valid,
      .decSrc2, .decSrc2Valid, .decImm, .decUseImm
   );

   operandRead #(.dataWidth(dataWidth)) read_i (
      .clk, .rstN,
      .decValid, .decOpcode, .decDest, .decSrc1, .decSrc1Valid,
      .decSrc2, .decSrc2Valid, .decImm, .decUseImm,
      .exValid, .exDest, .wbValid, .wbDest, .registerFile,
      .stall, .rdValid, .rdOpcode, .rdDest, .rdOperand1, .rdOperand2,
      .rdImm, .rdUseImm
   );

   aluExecute #(.dataWidth(dataWidth)) execute_i (
      .clk, .rstN, .rdValid, .rdOpcode, .rdDest, .rdOperand1, .rdOperand2,
      .rdImm, .rdUseImm, .exValid, .exDest, .exValue
   );

   resultWriteback #(.dataWidth(dataWidth)) writeback_i (
      .clk, .rstN, .exValid, .exDest, .exValue, .registerFile,
      .wbValid, .wbDest, .resultValid, .resultReg, .resultValue
   );

endmodule

//--- sim/miniCore_chk.sv
module miniCore_chk (
   input logic                clk,
   input logic                rstN,
   input logic                instrValid,
   input corePkg::instrWord   instr,
   input logic                stall,
   input logic                resultValid
);

   int acceptTotal;
   int resultTotal;

   // accepted instructions and results since reset.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         acceptTotal <= 0;
         resultTotal <= 0;
      end else begin
         if (instrValid && !stall) begin
            acceptTotal <= acceptTotal + 1;
         end
         if (resultValid) begin
            resultTotal <= resultTotal + 1;
         end
      end
   end

   quietInReset: assert property (@(posedge clk) !rstN |-> (!stall && !resultValid))
      else $error("stall or resultValid high during reset");

   // the pair needs two acceptances beyond the results before it.
   backToBackResults: assert property (@(posedge clk) disable iff (!rstN)
      (resultValid && $past(resultValid)) |-> (acceptTotal > resultTotal))
      else $error("two results in a row without two accepted instructions");

   holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
      (stall && instrValid) |=> $stable(instr))
      else $error("instr changed while stalled");

endmodule

//--- sim/miniCoreMonitor.sv
module miniCoreMonitor #(
   parameter int dataWidth = 64
) (
   input logic                               clk,
   input logic                               rstN,
   input logic                               resultValid,
   input logic [corePkg::regIdxWidth-1:0]    resultReg,
   input logic [dataWidth-1:0]               resultValue
);

   logic [dataWidth-1:0] model [corePkg::numRegs];
   int checks = 0;
   int mismatches = 0;

   initial begin
      for (int i = 0; i < corePkg::numRegs; i++) begin
         model[i] = '0;
      end
   end

   // entries without a result (illegal opcodes) are dropped from the head.
   function automatic logic headHasResult();
      logic [dataWidth+4:0] pred;
      pred = miniCoreTb.expectResult(miniCoreTb.acceptedQ[0], model);
      return pred[dataWidth+4];
   endfunction

   always @(negedge clk) begin : watch
      logic [dataWidth+4:0] pred;
      logic [corePkg::regIdxWidth-1:0] expReg;
      logic [dataWidth-1:0] expValue;
      int latency;
      if (rstN) begin
         while (miniCoreTb.acceptedQ.size() > 0 && !headHasResult()) begin
            void'(miniCoreTb.acceptedQ.pop_front());
            void'(miniCoreTb.acceptCycle.pop_front());
         end
         if (resultValid) begin
            if (miniCoreTb.acceptedQ.size() == 0) begin
               $display("result on register %0d at %0t with no instruction pending",
                        resultReg, $time);
               mismatches++;
            end else begin
               pred = miniCoreTb.expectResult(miniCoreTb.acceptedQ.pop_front(), model);
               latency = miniCoreTb.cycleCount - miniCoreTb.acceptCycle.pop_front();
               expReg = pred[dataWidth+3:dataWidth];
               expValue = pred[dataWidth-1:0];
               checks++;
               if (resultReg !== expReg) begin
                  $display("Error at %0t: resultReg expected %0d, got %0d",
                           $time, expReg, resultReg);
                  mismatches++;
               end
               if (resultValue !== expValue) begin
                  $display("Error at %0t: resultValue expected %h, got %h",
                           $time, expValue, resultValue);
                  mismatches++;
               end
               if (miniCoreTb.checkLatency && latency != 3) begin
                  $display("Error at %0t: result latency expected 3, got %0d",
                           $time, latency);
                  mismatches++;
               end
               model[expReg] = expValue;
            end
         end
      end
   end

endmodule

//--- sim/miniCoreTb.sv
module miniCoreTb;

   localparam int dataWidth = 64;

   logic clk;
   logic rstN;
   logic instrValid;
   corePkg::instrWord instr;
   logic stall;
   logic resultValid;
   logic [corePkg::regIdxWidth-1:0] resultReg;
   logic [dataWidth-1:0] resultValue;

   // accepted instructions in order, read by the monitor.
   corePkg::instrWord acceptedQ [$];
   int acceptCycle [$];
   int cycleCount = 0;
   logic checkLatency = 1'b0;
   logic timedOut = 1'b0;
   logic sawStall = 1'b0;
   int tbErrors = 0;
   logic [31:0] rnd;
   logic [7:0] legalOps [9];

   miniCore #(.dataWidth(dataWidth)) miniCore_i (
      .clk, .rstN, .instrValid, .instr, .stall, .resultValid, .resultReg, .resultValue
   );

   miniCoreMonitor #(.dataWidth(dataWidth)) mon_i (
      .clk, .rstN, .resultValid, .resultReg, .resultValue
   );

   bind miniCore miniCore_chk chk_i (
      .clk, .rstN, .instrValid, .instr, .stall, .resultValid
   );

   always #5 clk = ~clk;

   always @(posedge clk) cycleCount <= cycleCount + 1;

   // reference model, returns {due, register, value} from the ISA rules.
   function automatic logic [dataWidth+4:0] expectResult(
      input corePkg::instrWord w,
      input logic [dataWidth-1:0] regs [corePkg::numRegs]
   );
      logic [7:0] op;
      logic [dataWidth-1:0] a;
      logic [dataWidth-1:0] b;
      logic [dataWidth-1:0] v;
      logic signed [dataWidth-1:0] immExt;
      logic due;
      op = w.regForm.opcode;
      immExt = w.immForm.imm;
      a = regs[w.regForm.src1];
      b = op[7] ? immExt : regs[w.regForm.src2];
      due = 1'b1;
      case (op)
         8'h01, 8'h81: v = a + b;
         8'h02: v = a - b;
         8'h03: v = a & b;
         8'h04: v = a | b;
         8'h05: v = a ^ b;
         8'h06: v = a;
         8'h86: v = b;
         8'h07: v = a << b[5:0];
         default: begin
            v = '0;
            due = 1'b0;
         end
      endcase
      return {due, w.regForm.dest, v};
   endfunction

   function automatic corePkg::instrWord regInstr(input logic [7:0] op,
      input logic [3:0] d, input logic [3:0] s1, input logic [3:0] s2);
      corePkg::instrWord w;
      w.regForm = '{opcode: op, dest: d, src1: s1, src2: s2, unused: '0};
      return w;
   endfunction

   function automatic corePkg::instrWord immInstr(input logic [7:0] op,
      input logic [3:0] d, input logic [3:0] s1, input logic [15:0] imm);
      corePkg::instrWord w;
      w.immForm = '{opcode: op, dest: d, src1: s1, imm: imm};
      return w;
   endfunction

   // holds the word until an edge with stall low takes it.
   task automatic issue(input corePkg::instrWord w);
      logic accepted;
      int waitCnt;
      accepted = 1'b0;
      waitCnt = 0;
      instr = w;
      instrValid = 1'b1;
      while (!accepted && !timedOut) begin
         @(negedge clk);
         if (stall) begin
            sawStall = 1'b1;
            waitCnt++;
            if (waitCnt > 50) begin
               $display("timeout: stall stayed high for 50 cycles at %0t", $time);
               timedOut = 1'b1;
            end
         end else begin
            accepted = 1'b1;
            acceptedQ.push_back(w);
            acceptCycle.push_back(cycleCount + 1);
         end
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drain();
      int waitCnt;
      waitCnt = 0;
      instrValid = 1'b0;
      while (acceptedQ.size() != 0 && !timedOut) begin
         @(negedge clk);
         waitCnt++;
         if (waitCnt > 200) begin
            $display("timeout: %0d results never appeared", acceptedQ.size());
            timedOut = 1'b1;
         end
      end
      @(posedge clk);
      #1;
   endtask

   task automatic report(input int num, input string name);
      $display("test %0d %s finished, mismatches so far %0d", num, name,
               mon_i.mismatches + tbErrors);
   endtask

   initial begin
      void'($urandom(56));
      legalOps = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h81, 8'h86};
      clk = 1'b0;
      rstN = 1'b0;
      instrValid = 1'b0;
      instr = '0;
      repeat (8) @(posedge clk);
      #1;
      rstN = 1'b1;

      // nothing may come out before the first acceptance.
      repeat (6) begin
         @(negedge clk);
         if (resultValid !== 1'b0) begin
            $display("resultValid rose at %0t before any instruction", $time);
            tbErrors++;
         end
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < 16; i++) begin
         issue(regInstr(8'h06, 4'(i), 4'(i), 4'd0));
      end
      drain();
      report(1, "reset state");

      for (int i = 1; i < 9; i++) begin
         rnd = $urandom;
         issue(immInstr(8'h86, 4'(i), 4'd0, rnd[15:0]));
      end
      for (int i = 0; i < 30; i++) begin
         rnd = $urandom;
         issue(regInstr(legalOps[rnd[7:0] % 7], rnd[11:8], rnd[15:12], rnd[19:16]));
      end
      drain();
      report(2, "register form");

      issue(immInstr(8'h86, 4'd3, 4'd0, 16'h8001));
      issue(immInstr(8'h86, 4'd4, 4'd0, 16'h7fff));
      issue(immInstr(8'h81, 4'd5, 4'd3, 16'hffff));
      issue(immInstr(8'h81, 4'd6, 4'd4, 16'h0010));
      issue(immInstr(8'h81, 4'd7, 4'd9, 16'hfe00));
      drain();
      report(3, "immediate form");

      sawStall = 1'b0;
      issue(immInstr(8'h86, 4'd1, 4'd0, 16'd5));
      for (int i = 0; i < 4; i++) begin
         issue(immInstr(8'h81, 4'd1, 4'd1, 16'd3));
      end
      issue(regInstr(8'h01, 4'd2, 4'd1, 4'd1));
      issue(regInstr(8'h07, 4'd2, 4'd2, 4'd1));
      drain();
      if (!sawStall) begin
         $display("stall never rose during the dependent chain");
         tbErrors++;
      end
      // independent movi words never hit a hazard.
      checkLatency = 1'b1;
      for (int i = 10; i < 16; i++) begin
         issue(immInstr(8'h86, 4'(i), 4'd0, 16'(i * 7)));
      end
      drain();
      checkLatency = 1'b0;
      report(4, "hazards and latency");

      issue(immInstr(8'h86, 4'd1, 4'd0, 16'd11));
      issue(regInstr(8'h00, 4'd1, 4'd1, 4'd1));
      issue(regInstr(8'h01, 4'd2, 4'd1, 4'd1));
      issue(regInstr(8'hff, 4'd2, 4'd2, 4'd2));
      issue(regInstr(8'h42, 4'd3, 4'd0, 4'd0));
      issue(immInstr(8'h81, 4'd3, 4'd2, 16'hfff0));
      drain();
      report(5, "illegal opcodes");

      for (int i = 0; i < 200; i++) begin
         rnd = $urandom;
         if (rnd[2:0] == 3'd0) begin
            issue(regInstr(8'h08 + 8'(rnd[7:4]), rnd[11:8], rnd[15:12], rnd[19:16]));
         end else if (rnd[3]) begin
            issue(immInstr(legalOps[7 + rnd[4]], rnd[11:8], rnd[15:12], rnd[31:16]));
         end else begin
            issue(regInstr(legalOps[rnd[31:24] % 7], rnd[11:8], rnd[15:12], rnd[19:16]));
         end
      end
      drain();
      report(6, "random stream");

      $display("checks %0d, mismatches %0d, other errors %0d, queue left %0d",
               mon_i.checks, mon_i.mismatches, tbErrors, acceptedQ.size());
      if (!timedOut && mon_i.mismatches == 0 && tbErrors == 0 && acceptedQ.size() == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- sim.f
hw/corePkg.sv
hw/opcodeDecode.sv
hw/operandRead.sv
hw/aluExecute.sv
hw/resultWriteback.sv
hw/miniCore.sv
sim/miniCore_chk.sv
sim/miniCoreMonitor.sv
sim/miniCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module miniCoreTb -o simv \
   > build.log 2>&1 \
   && ./obj_dir/simv > sim.log 2>&1 \
   || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
